//--- flist.f
logic/icache_pkg.sv
logic/icache_tagv.sv
logic/icache_data_ram.sv
logic/icache_refill_buf.sv
logic/icache_plru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/icache_clk_gen.sv
verif/icache_checker.sv
verif/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the icache testbench with Verilator, run it and inspect the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module icache_tb \
    -f flist.f -Mdir "$BUILD_DIR" -o icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/icache_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- verif/icache_testdata.txt
# pc (hex)  cookie (hex)  expected miss (1 = one r_req, 0 = hit or misaligned)
# set 1 warm-up, misaligned cases, set 5 eviction order, set 63 two ways
00001040 0001 1
00001048 0002 0
00001078 0003 0
00001044 0004 0
00001042 0005 0
00001050 0006 0
00002082 0007 0
00002080 0008 1
00010140 0011 1
00020140 0012 1
00030148 0013 1
00040150 0014 1
00050178 0015 1
00020160 0016 0
00010140 0017 1
00040158 0018 0
00050140 0019 0
00030140 001a 1
00010148 001b 1
00100fc0 0021 1
00100ff8 0022 0
00001070 0023 0
00200fc4 0024 1
00100ffc 0025 0

//--- verif/icache_tb.sv
`timescale 1ns/1ps
module icache_tb;
    import icache_pkg::*;

    localparam int COOKIE_WIDTH = 16;
    localparam int MAX_REQ      = 64;

    typedef struct packed {
        int idx;         // entry in the request list
        int acc_cycle;   // cycle the DUT took it
    } pending_t;

    logic                    clk, rst, valid, cache_ready, data_valid, exception;
    logic                    r_req, r_rdy, ret_valid, ret_last, r_data_ready, fire;
    addr_t                   pc_in, pc_out, r_addr;
    logic [COOKIE_WIDTH-1:0] cookie_in, cookie_out;
    dword_t                  r_data;
    word_t                   r_data_mem;

    addr_t                   req_pc [MAX_REQ];
    logic [COOKIE_WIDTH-1:0] req_cookie [MAX_REQ];
    logic                    req_miss [MAX_REQ];
    pending_t                pend_q [$];   // accepted, result not yet seen
    int n_req      = 0;
    int n_accepted = 0;
    int cycle      = 0;
    int limit      = 0;
    int errors     = 0;
    int checks     = 0;
    int hs_count   = 0;                    // memory handshakes for the head request
    int seed       = 32'h6d28_4b94;

    icache_clk_gen #(.RESET_CYCLES(10)) u_clk_gen (.clk(clk), .rst(rst));

    icache_top #(.COOKIE_WIDTH(COOKIE_WIDTH)) u_dut (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .pc_in        (pc_in),
        .cookie_in    (cookie_in),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .r_data       (r_data),
        .pc_out       (pc_out),
        .cookie_out   (cookie_out),
        .exception    (exception),
        .r_req        (r_req),
        .r_addr       (r_addr),
        .r_rdy        (r_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .r_data_ready (r_data_ready),
        .r_data_mem   (r_data_mem)
    );

    // memory contents are a function of the address
    function automatic word_t mem_word(input addr_t a);
        return (a ^ 32'hA5A5_0000) + 32'd1;
    endfunction

    function automatic dword_t expected_dword(input addr_t pc);
        addr_t base;
        base = {pc[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_result(input pending_t p);
        addr_t pc;
        logic  misaligned;
        pc = req_pc[p.idx];
        misaligned = (pc[1:0] != 2'b00);
        check_value("pc_out", 64'(pc_out), 64'(pc));
        check_value("cookie_out", 64'(cookie_out), 64'(req_cookie[p.idx]));
        check_value("exception", 64'(exception), 64'(misaligned));
        check_value("r_data", r_data, misaligned ? 64'd0 : expected_dword(pc));
        check_value("r_req count", 64'(hs_count), 64'(req_miss[p.idx]));
        if (!req_miss[p.idx]) begin
            checks++;
            assert (cycle == p.acc_cycle + 1) else begin
                $display("request %0d returned %0d cycles after acceptance instead of 1",
                         p.idx, cycle - p.acc_cycle);
                errors++;
            end
        end
    endtask

    // sample mid-cycle, away from the driving edge
    always @(negedge clk) begin : monitor
        pending_t head, entry;
        if (rst) begin
            fire = 1'b0;
        end else begin
            fire = valid && cache_ready;
            if (r_req && r_rdy) begin
                hs_count++;
                assert (pend_q.size() != 0) else begin
                    $display("memory request issued with no fetch outstanding");
                    errors++;
                end
                if (pend_q.size() != 0) begin
                    check_value("r_addr", 64'(r_addr),
                                64'({req_pc[pend_q[0].idx][31:6], 6'b0}));
                end
            end
            if (ret_valid) begin
                check_value("r_data_ready", 64'(r_data_ready), 64'd1);
            end
            if (data_valid) begin
                assert (pend_q.size() != 0) else begin
                    $display("data_valid raised with no fetch outstanding");
                    errors++;
                end
                if (pend_q.size() != 0) begin
                    head = pend_q.pop_front();
                    check_result(head);
                end
                hs_count = 0;
            end
            if (fire) begin
                entry.idx = n_accepted;
                entry.acc_cycle = cycle;
                pend_q.push_back(entry);
                n_accepted++;
            end
        end
    end

    initial begin : memory_model
        addr_t line_addr;
        int    delay, gap;
        r_rdy      <= 1'b0;
        ret_valid  <= 1'b0;
        ret_last   <= 1'b0;
        r_data_mem <= '0;
        forever begin
            @(negedge clk);
            if (!rst && r_req) begin
                line_addr = r_addr;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                r_rdy <= 1'b1;
                @(posedge clk);
                r_rdy <= 1'b0;   // handshake taken at this edge
                for (int i = 0; i < LINE_WORDS; i++) begin
                    gap = $unsigned($random(seed)) % 3;
                    repeat (gap) begin
                        @(posedge clk);
                        ret_valid <= 1'b0;
                        ret_last  <= 1'b0;
                    end
                    @(posedge clk);
                    ret_valid  <= 1'b1;
                    ret_last   <= (i == LINE_WORDS - 1);
                    r_data_mem <= mem_word(line_addr + 32'(4 * i));
                end
                @(posedge clk);
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle <= cycle + 1;
        if (limit > 0 && cycle > limit) begin
            $display("timeout after %0d cycles, %0d of %0d requests accepted",
                     cycle, n_accepted, n_req);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int                fd, code, idx, chk_fails;
        logic [8*80-1:0]   text;
        logic [31:0]       pc_v, cookie_v, miss_v;
        valid     <= 1'b0;
        pc_in     <= '0;
        cookie_in <= '0;
        fd = $fopen("verif/icache_testdata.txt", "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                code = $sscanf(text, "%h %h %d", pc_v, cookie_v, miss_v);
                if (code == 3 && n_req < MAX_REQ) begin
                    req_pc[n_req]     = pc_v;
                    req_cookie[n_req] = cookie_v[COOKIE_WIDTH-1:0];
                    req_miss[n_req]   = miss_v[0];
                    n_req++;
                end
            end
            $fclose(fd);
        end
        limit = n_req * 60 + 200;
        @(negedge rst);
        @(posedge clk);
        idx = 0;
        if (n_req > 0) begin
            valid     <= 1'b1;
            pc_in     <= req_pc[0];
            cookie_in <= req_cookie[0];
        end
        while (idx < n_req) begin
            @(posedge clk);
            if (fire) begin
                idx++;
                if (idx < n_req) begin
                    pc_in     <= req_pc[idx];
                    cookie_in <= req_cookie[idx];
                end else begin
                    valid <= 1'b0;
                end
            end
        end
        while (n_accepted < n_req || pend_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        chk_fails = u_dut.u_checker.fail_total;
        if (n_req == 0) begin
            $display("no requests could be read from verif/icache_testdata.txt");
            chk_fails++;
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/icache_checker.sv
`timescale 1ns/1ps
module icache_checker (
    input logic clk,
    input logic rst,
    input logic r_req,
    input logic r_rdy,
    input logic data_valid,
    input logic exception,
    input logic r_data_ready
);
    int req_fails   = 0;
    int reset_fails = 0;
    int resp_fails  = 0;
    int fail_total;

    assign fail_total = req_fails + reset_fails + resp_fails;

    // memory request held until taken
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (r_req && !r_rdy) |=> r_req)
        else begin
            $error("r_req dropped before the memory accepted it");
            req_fails++;
        end

    // outputs quiet from the first reset edge on
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!r_req && !data_valid && !exception))
        else begin
            $error("r_req, data_valid or exception active during reset");
            reset_fails++;
        end

    a_no_resp_in_refill: assert property (@(posedge clk) disable iff (rst)
        !(data_valid && r_data_ready))
        else begin
            $error("data_valid raised while a refill is still in progress");
            resp_fails++;
        end

endmodule

bind icache_top icache_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .r_req        (r_req),
    .r_rdy        (r_rdy),
    .data_valid   (data_valid),
    .exception    (exception),
    .r_data_ready (r_data_ready)
);

//--- verif/icache_clk_gen.sv
`timescale 1ns/1ps
module icache_clk_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- logic/icache_top.sv
`timescale 1ns/1ps
module icache_top #(
    parameter int COOKIE_WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    // fetch side
    input  logic                     valid,
    input  icache_pkg::addr_t        pc_in,
    input  logic [COOKIE_WIDTH-1:0]  cookie_in,
    output logic                     cache_ready,
    output logic                     data_valid,
    output icache_pkg::dword_t       r_data,
    output icache_pkg::addr_t        pc_out,
    output logic [COOKIE_WIDTH-1:0]  cookie_out,
    output logic                     exception,
    // memory side
    output logic                     r_req,
    output icache_pkg::addr_t        r_addr,
    input  logic                     r_rdy,
    input  logic                     ret_valid,
    input  logic                     ret_last,
    output logic                     r_data_ready,
    input  icache_pkg::word_t        r_data_mem
);
    import icache_pkg::*;

    pc_fields_t                rd_fields, wr_fields;
    way_mask_t                 hit, valid_ways, victim, line_we, touch_way;
    dword_t [NUM_WAYS-1:0]     way_dout;
    line_t                     fill_line;
    tagv_entry_t               tag_wr;
    logic                      fill_done, touch;

    icache_ctrl #(.COOKIE_WIDTH(COOKIE_WIDTH)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .pc_in        (pc_in),
        .cookie_in    (cookie_in),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .r_data       (r_data),
        .pc_out       (pc_out),
        .cookie_out   (cookie_out),
        .exception    (exception),
        .r_req        (r_req),
        .r_addr       (r_addr),
        .r_rdy        (r_rdy),
        .r_data_ready (r_data_ready),
        .rd_fields    (rd_fields),
        .hit          (hit),
        .way_dout     (way_dout),
        .fill_done    (fill_done),
        .fill_line    (fill_line),
        .victim       (victim),
        .line_we      (line_we),
        .wr_fields    (wr_fields),
        .tag_wr       (tag_wr),
        .touch        (touch),
        .touch_way    (touch_way)
    );

    icache_tagv u_tagv (
        .clk        (clk),
        .rst        (rst),
        .rd_fields  (rd_fields),
        .wr_fields  (wr_fields),
        .we         (line_we),      // tag written with its line
        .tag_wr     (tag_wr),
        .hit        (hit),
        .valid_ways (valid_ways)
    );

    icache_data_ram u_data_ram (
        .clk       (clk),
        .rd_fields (rd_fields),
        .wr_fields (wr_fields),
        .line_we   (line_we),
        .fill_line (fill_line),
        .way_dout  (way_dout)
    );

    icache_refill_buf u_refill_buf (
        .clk        (clk),
        .rst        (rst),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .r_data_mem (r_data_mem),
        .fill_done  (fill_done),
        .fill_line  (fill_line)
    );

    icache_plru u_plru (
        .clk        (clk),
        .rst        (rst),
        .set        (wr_fields.index),   // set of the buffered request
        .valid_ways (valid_ways),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim     (victim)
    );

endmodule

//--- logic/icache_ctrl.sv
`timescale 1ns/1ps
module icache_ctrl #(
    parameter int COOKIE_WIDTH = 32
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           valid,
    input  icache_pkg::addr_t                              pc_in,
    input  logic [COOKIE_WIDTH-1:0]                        cookie_in,
    output logic                                           cache_ready,
    output logic                                           data_valid,
    output icache_pkg::dword_t                             r_data,
    output icache_pkg::addr_t                              pc_out,
    output logic [COOKIE_WIDTH-1:0]                        cookie_out,
    output logic                                           exception,
    output logic                                           r_req,
    output icache_pkg::addr_t                              r_addr,
    input  logic                                           r_rdy,
    output logic                                           r_data_ready,
    output icache_pkg::pc_fields_t                         rd_fields,
    input  icache_pkg::way_mask_t                          hit,
    input  icache_pkg::dword_t [icache_pkg::NUM_WAYS-1:0]  way_dout,
    input  logic                                           fill_done,
    input  icache_pkg::line_t                              fill_line,
    input  icache_pkg::way_mask_t                          victim,
    output icache_pkg::way_mask_t                          line_we,
    output icache_pkg::pc_fields_t                         wr_fields,
    output icache_pkg::tagv_entry_t                        tag_wr,
    output logic                                           touch,
    output icache_pkg::way_mask_t                          touch_way
);
    import icache_pkg::*;

    ctrl_state_t             state, state_nxt;
    addr_t                   pc_q;       // request buffer
    logic [COOKIE_WIDTH-1:0] cookie_q;
    way_mask_t               victim_q;   // way chosen at miss time
    pc_fields_t              req;
    logic                    accept, misaligned, hit_any, lookup_done;
    dword_t                  hit_data;

    assign req         = pc_q;
    assign rd_fields   = pc_in;            // tag/data read address at accept
    assign wr_fields   = req;
    assign misaligned  = (req.byte_off != 2'b00);
    assign hit_any     = |hit;
    assign lookup_done = (state == LOOKUP) && (hit_any || misaligned);
    assign accept      = valid && cache_ready;

    assign cache_ready  = (state == IDLE) || (state == RESP) || lookup_done;
    assign data_valid   = lookup_done || (state == RESP);
    assign exception    = (state == LOOKUP) && misaligned;
    assign r_req        = (state == MISS_REQ);
    assign r_addr       = {pc_q[31:6], 6'b0};
    assign r_data_ready = (state == REFILL) && !fill_done;
    assign pc_out       = pc_q;
    assign cookie_out   = cookie_q;

    assign line_we   = (state == WRITE_LINE) ? victim_q : '0;
    assign tag_wr    = '{valid: 1'b1, tag: req.tag};
    assign touch     = ((state == LOOKUP) && hit_any && !misaligned) || (state == WRITE_LINE);
    assign touch_way = (state == WRITE_LINE) ? victim_q : hit;

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit[w]) hit_data = hit_data | way_dout[w];   // hit is one-hot
        end
    end

    always_comb begin
        if (state == RESP) r_data = fill_line[{req.dw_off, 6'b0} +: 64];
        else if (misaligned) r_data = '0;
        else r_data = hit_data;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (accept) state_nxt = LOOKUP;
            LOOKUP:     if (!lookup_done) state_nxt = MISS_REQ;
                        else state_nxt = accept ? LOOKUP : IDLE;
            MISS_REQ:   if (r_rdy) state_nxt = REFILL;
            REFILL:     if (fill_done) state_nxt = WRITE_LINE;
            WRITE_LINE: state_nxt = RESP;
            RESP:       state_nxt = accept ? LOOKUP : IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= IDLE;
        else state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q     <= pc_in;
            cookie_q <= cookie_in;
        end
        if ((state == LOOKUP) && !lookup_done) victim_q <= victim;
    end

endmodule

//--- logic/icache_plru.sv
`timescale 1ns/1ps
module icache_plru (
    input  logic                   clk,
    input  logic                   rst,
    input  icache_pkg::index_t     set,
    input  icache_pkg::way_mask_t  valid_ways,
    input  logic                   touch,
    input  icache_pkg::way_mask_t  touch_way,
    output icache_pkg::way_mask_t  victim
);
    import icache_pkg::*;

    // bit 0 root (0 = left pair), bit 1 picks in ways 0/1, bit 2 in ways 2/3
    logic [2:0] tree [NUM_SETS];
    logic [2:0] cur;

    assign cur = tree[set];

    always_comb begin
        victim = '0;
        if (!valid_ways[0])      victim = 4'b0001;   // fill empty ways first
        else if (!valid_ways[1]) victim = 4'b0010;
        else if (!valid_ways[2]) victim = 4'b0100;
        else if (!valid_ways[3]) victim = 4'b1000;
        else if (!cur[0])        victim = cur[1] ? 4'b0010 : 4'b0001;
        else                     victim = cur[2] ? 4'b1000 : 4'b0100;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            // point the tree away from the used way
            if (touch_way[0] || touch_way[1]) begin
                tree[set][0] <= 1'b1;
                tree[set][1] <= touch_way[0];
            end else begin
                tree[set][0] <= 1'b0;
                tree[set][2] <= touch_way[2];
            end
        end
    end

endmodule

//--- logic/icache_refill_buf.sv
`timescale 1ns/1ps
module icache_refill_buf (
    input  logic               clk,
    input  logic               rst,
    input  logic               ret_valid,
    input  logic               ret_last,
    input  icache_pkg::word_t  r_data_mem,
    output logic               fill_done,
    output icache_pkg::line_t  fill_line
);
    import icache_pkg::*;

    localparam int LINE_BITS = LINE_WORDS * 32;

    // beats arrive in address order, so shifting down from the top
    // leaves word 0 in the low bits after the final beat
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            fill_line <= {r_data_mem, fill_line[LINE_BITS-1:32]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_done <= 1'b0;
        end else begin
            fill_done <= ret_valid && ret_last;   // one-cycle pulse
        end
    end

endmodule

//--- logic/icache_data_ram.sv
`timescale 1ns/1ps
module icache_data_ram (
    input  logic                                           clk,
    input  icache_pkg::pc_fields_t                         rd_fields,
    input  icache_pkg::pc_fields_t                         wr_fields,
    input  icache_pkg::way_mask_t                          line_we,
    input  icache_pkg::line_t                              fill_line,
    output icache_pkg::dword_t [icache_pkg::NUM_WAYS-1:0]  way_dout
);
    import icache_pkg::*;

    line_t      line_mem [NUM_WAYS][NUM_SETS];
    logic [8:0] rd_bit;   // bit offset of the doubleword in the line

    assign rd_bit = {rd_fields.dw_off, 6'b0};

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (line_we[w]) begin
                line_mem[w][wr_fields.index] <= fill_line;   // whole line at once
            end
            way_dout[w] <= line_mem[w][rd_fields.index][rd_bit +: 64];
        end
    end

endmodule

//--- logic/icache_tagv.sv
`timescale 1ns/1ps
module icache_tagv (
    input  logic                    clk,
    input  logic                    rst,
    input  icache_pkg::pc_fields_t  rd_fields,
    input  icache_pkg::pc_fields_t  wr_fields,
    input  icache_pkg::way_mask_t   we,
    input  icache_pkg::tagv_entry_t tag_wr,
    output icache_pkg::way_mask_t   hit,
    output icache_pkg::way_mask_t   valid_ways
);
    import icache_pkg::*;

    tagv_entry_t tagv_mem [NUM_WAYS][NUM_SETS];
    tagv_entry_t rd_entry [NUM_WAYS];   // entries of the looked-up set
    tag_t        rd_tag;                // tag of the pc being compared

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    tagv_mem[w][s] <= '0;
                end
                rd_entry[w] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (we[w]) begin
                    tagv_mem[w][wr_fields.index] <= tag_wr;
                end
                rd_entry[w] <= tagv_mem[w][rd_fields.index];   // sync read
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_tag <= rd_fields.tag;
    end

    // compare stage one cycle after the read address
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            valid_ways[w] = rd_entry[w].valid;
            hit[w]        = rd_entry[w].valid && (rd_entry[w].tag == rd_tag);
        end
    end

endmodule

//--- logic/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 64;
    localparam int LINE_WORDS = 16;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [63:0]  dword_t;
    typedef logic [511:0] line_t;
    typedef logic [19:0]  tag_t;
    typedef logic [5:0]   index_t;
    typedef logic [3:0]   way_mask_t;   // one-hot way select

    // pc split into tag 31..12, index 11..6, dword 5..3, word 2, byte 1..0
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic [2:0] dw_off;
        logic       word_sel;
        logic [1:0] byte_off;
    } pc_fields_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        REFILL,
        WRITE_LINE,
        RESP
    } ctrl_state_t;

endpackage
